//--- hw/cu_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types and constants of the exception control unit
// Only the RV32 encodings the control unit reacts to are listed
//////////////////////////////////////////////////////////////////////

package cu_pkg;

	// Field widths
	localparam int ILEN        = 32;
	localparam int OPCODE_LEN  = 7;
	localparam int FUNCT3_LEN  = 3;
	localparam int FUNCT7_LEN  = 7;
	localparam int IMM12_LEN   = 12;
	localparam int EXCEPT_LEN  = 4;
	localparam int ROB_IDX_LEN = 3;

	typedef logic [ILEN-1:0]        instr_t;
	typedef logic [EXCEPT_LEN-1:0]  except_code_t;
	typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;

	localparam rob_idx_t ROB_LAST = '1;

	// RISC-V exception causes
	localparam except_code_t E_I_ADDR_MISALIGNED   = 4'd0;
	localparam except_code_t E_I_ACCESS_FAULT      = 4'd1;
	localparam except_code_t E_ILLEGAL_INSTRUCTION = 4'd2;
	localparam except_code_t E_LD_ADDR_MISALIGNED  = 4'd4;
	localparam except_code_t E_LD_ACCESS_FAULT     = 4'd5;
	localparam except_code_t E_ST_ADDR_MISALIGNED  = 4'd6;
	localparam except_code_t E_ST_ACCESS_FAULT     = 4'd7;
	localparam except_code_t E_ENV_CALL_SMODE      = 4'd9;
	localparam except_code_t E_ENV_CALL_MMODE      = 4'd11;
	localparam except_code_t E_INSTR_PAGE_FAULT    = 4'd12;
	localparam except_code_t E_LD_PAGE_FAULT       = 4'd13;
	localparam except_code_t E_ST_PAGE_FAULT       = 4'd15;

	// Major opcodes
	localparam logic [OPCODE_LEN-1:0] OPCODE_JAL      = 7'b1101111;
	localparam logic [OPCODE_LEN-1:0] OPCODE_BRANCH   = 7'b1100011;
	localparam logic [OPCODE_LEN-1:0] OPCODE_LOAD     = 7'b0000011;
	localparam logic [OPCODE_LEN-1:0] OPCODE_STORE    = 7'b0100011;
	localparam logic [OPCODE_LEN-1:0] OPCODE_MISC_MEM = 7'b0001111; // fence, fence.i
	localparam logic [OPCODE_LEN-1:0] OPCODE_SYSTEM   = 7'b1110011;

	localparam logic [FUNCT3_LEN-1:0] FUNCT3_PRIV       = 3'b000;
	localparam logic [FUNCT7_LEN-1:0] FUNCT7_SFENCE_VMA = 7'b0001001;

	// Immediate field of the privileged SYSTEM group
	localparam logic [IMM12_LEN-1:0] IMM_ECALL  = 12'h000;
	localparam logic [IMM12_LEN-1:0] IMM_EBREAK = 12'h001;

	typedef enum logic [3:0] {
		CLS_OTHER,
		CLS_JUMP,
		CLS_LDST,
		CLS_BRANCH,
		CLS_FENCE,
		CLS_SFENCE,
		CLS_ECALL,
		CLS_EBREAK
	} instr_class_t;

	typedef enum logic [3:0] {
		ST_RESET,
		ST_RESUME,
		ST_JUMP,
		ST_LDST,
		ST_BRANCH,
		ST_FENCE,
		ST_WAIT,
		ST_ECALL,
		ST_EBREAK
	} cu_state_e;

	typedef enum logic [1:0] {
		NO_FLUSH,
		FLUSH_ASID,
		FLUSH_ALL
	} tlb_flush_e;

endpackage

//--- hw/cu_instr_decode.sv
//////////////////////////////////////////////////////////////////////
// Purely combinational, so the class follows instr_i in the same cycle
// SYSTEM encodings other than ecall, ebreak and sfence.vma give CLS_OTHER
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module cu_instr_decode import cu_pkg::*; (
	input  instr_t       instr_i,
	input  logic         instr_valid_i,
	output instr_class_t instr_class_o
);

	logic [OPCODE_LEN-1:0] opcode;
	logic [FUNCT3_LEN-1:0] funct3;
	logic [FUNCT7_LEN-1:0] funct7;
	logic [IMM12_LEN-1:0]  imm12;

	assign opcode = instr_i[OPCODE_LEN-1:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];
	assign imm12  = instr_i[31:20];

	always_comb begin
		instr_class_o = CLS_OTHER;

		if (instr_valid_i) begin
			unique case (opcode)
				OPCODE_JAL: instr_class_o = CLS_JUMP;
				OPCODE_BRANCH: instr_class_o = CLS_BRANCH;
				OPCODE_LOAD,
				OPCODE_STORE: instr_class_o = CLS_LDST;
				OPCODE_MISC_MEM: instr_class_o = CLS_FENCE;  // Both fence and fence.i
				OPCODE_SYSTEM: begin
					if (funct3 == FUNCT3_PRIV) begin
						// sfence.vma carries rs1/rs2 in the low imm bits
						if (funct7 == FUNCT7_SFENCE_VMA) begin
							instr_class_o = CLS_SFENCE;
						end else if (imm12 == IMM_ECALL) begin
							instr_class_o = CLS_ECALL;
						end else if (imm12 == IMM_EBREAK) begin
							instr_class_o = CLS_EBREAK;
						end
					end
				end
				default: instr_class_o = CLS_OTHER;
			endcase
		end
	end

endmodule

//--- hw/cu_ctrl_fsm.sv
//////////////////////////////////////////////////////////////////////
// Control FSM, one cycle from sampled inputs to the new state
// Fences wait in ST_WAIT for as long as l2c_update_done_i stays low
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module cu_ctrl_fsm import cu_pkg::*; (
	input  logic         clk_i,
	input  logic         rst_n_i,
	input  instr_class_t instr_class_i,
	input  logic         except_raised_i,
	input  logic         l2c_update_done_i,
	output cu_state_e    state_o,
	output instr_class_t held_class_o
);

	cu_state_e    state_q;
	cu_state_e    state_d;
	instr_class_t held_class_q;
	logic         leave_resume;

	// Next state
	always_comb begin
		state_d = state_q;

		unique case (state_q)
			ST_RESET: state_d = ST_RESUME;

			ST_RESUME: begin
				unique case (instr_class_i)
					// These only trap when the exception flag is up
					CLS_JUMP: begin
						if (except_raised_i) begin
							state_d = ST_JUMP;
						end
					end
					CLS_LDST: begin
						if (except_raised_i) begin
							state_d = ST_LDST;
						end
					end
					CLS_BRANCH: begin
						if (except_raised_i) begin
							state_d = ST_BRANCH;
						end
					end
					CLS_FENCE,
					CLS_SFENCE: state_d = ST_FENCE;
					CLS_ECALL: state_d = ST_ECALL;
					CLS_EBREAK: state_d = ST_EBREAK;
					default: state_d = ST_RESUME;
				endcase
			end

			ST_JUMP,
			ST_LDST,
			ST_BRANCH,
			ST_ECALL,
			ST_EBREAK: begin
				if (!except_raised_i) begin
					state_d = ST_RESUME;    // Held while the exception is up
				end
			end

			ST_FENCE: begin
				if (l2c_update_done_i) begin
					state_d = ST_RESUME;
				end else begin
					state_d = ST_WAIT;
				end
			end

			ST_WAIT: begin
				if (l2c_update_done_i) begin
					state_d = ST_RESUME;
				end
			end

			default: state_d = ST_RESET;
		endcase
	end

	assign leave_resume = (state_q == ST_RESUME) && (state_d != ST_RESUME);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_RESET;
		end else begin
			state_q <= state_d;
		end
	end

	// Class of the instruction that left ST_RESUME, used by the result stage
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			held_class_q <= CLS_OTHER;
		end else if (leave_resume) begin
			held_class_q <= instr_class_i;
		end
	end

	assign state_o      = state_q;
	assign held_class_o = held_class_q;

endmodule

//--- hw/cu_ctrl_result.sv
//////////////////////////////////////////////////////////////////////
// All outputs registered one cycle after the state
// except_code_i and commit_head_i are delayed a cycle to match the state
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module cu_ctrl_result import cu_pkg::*; (
	input  logic         clk_i,
	input  logic         rst_n_i,
	input  cu_state_e    state_i,
	input  instr_class_t held_class_i,
	input  except_code_t except_code_i,
	input  rob_idx_t     commit_head_i,
	output logic         flush_o,
	output logic         stall_o,
	output logic         abort_o,
	output logic         clr_l1tlb_mshr_o,
	output logic         clr_l2tlb_mshr_o,
	output logic         clr_dmshr_o,
	output logic         synch_l1dc_l2c_o,
	output tlb_flush_e   l1tlb_flush_type_o,
	output tlb_flush_e   l2tlb_flush_type_o
);

	except_code_t code_q;       // Taken with the instruction that set the state
	rob_idx_t     head_q;
	logic         flush_d;
	logic         stall_d;
	logic         abort_d;
	logic         clr_l1tlb_d;
	logic         clr_l2tlb_d;
	logic         clr_dmshr_d;
	logic         synch_d;
	tlb_flush_e   flush_type_d;   // Same type goes to both TLB levels

	// Code and head travel alongside the FSM state register
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			code_q <= '0;
			head_q <= '0;
		end else begin
			code_q <= except_code_i;
			head_q <= commit_head_i;
		end
	end

	always_comb begin
		flush_d      = 1'b0;
		stall_d      = 1'b0;
		abort_d      = 1'b0;
		clr_l1tlb_d  = 1'b0;
		clr_l2tlb_d  = 1'b0;
		clr_dmshr_d  = 1'b0;
		synch_d      = 1'b0;
		flush_type_d = NO_FLUSH;

		unique case (state_i)
			ST_RESET: begin
				// One-shot initialisation pulse
				flush_d      = 1'b1;
				clr_l1tlb_d  = 1'b1;
				clr_l2tlb_d  = 1'b1;
				clr_dmshr_d  = 1'b1;
				flush_type_d = FLUSH_ALL;
			end

			ST_JUMP,
			ST_BRANCH,
			ST_ECALL,
			ST_EBREAK: begin
				stall_d      = 1'b1;
				flush_type_d = FLUSH_ASID;
			end

			ST_LDST: begin
				stall_d = 1'b1;
				flush_d = (head_q == ROB_LAST);  // Faulting entry at the ROB end
				unique case (code_q)
					E_I_ADDR_MISALIGNED,
					E_I_ACCESS_FAULT,
					E_INSTR_PAGE_FAULT: begin
						clr_l1tlb_d = 1'b1;
						clr_l2tlb_d = 1'b1;
					end
					E_LD_ADDR_MISALIGNED,
					E_LD_ACCESS_FAULT,
					E_LD_PAGE_FAULT,
					E_ST_ADDR_MISALIGNED,
					E_ST_ACCESS_FAULT,
					E_ST_PAGE_FAULT: clr_dmshr_d = 1'b1;
					E_ILLEGAL_INSTRUCTION: abort_d = 1'b1;
					default: ;
				endcase
			end

			ST_FENCE: begin
				stall_d = 1'b1;
				synch_d = 1'b1;
				if (held_class_i == CLS_SFENCE) begin
					clr_l1tlb_d  = 1'b1;
					clr_l2tlb_d  = 1'b1;
					clr_dmshr_d  = 1'b1;
					flush_type_d = FLUSH_ALL;
				end
			end

			ST_WAIT: begin
				stall_d = 1'b1;
				synch_d = 1'b1;     // Keep requesting until L2 reports done
			end

			default: ;  // ST_RESUME is idle
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			flush_o            <= 1'b0;
			stall_o            <= 1'b0;
			abort_o            <= 1'b0;
			clr_l1tlb_mshr_o   <= 1'b0;
			clr_l2tlb_mshr_o   <= 1'b0;
			clr_dmshr_o        <= 1'b0;
			synch_l1dc_l2c_o   <= 1'b0;
			l1tlb_flush_type_o <= NO_FLUSH;
			l2tlb_flush_type_o <= NO_FLUSH;
		end else begin
			flush_o            <= flush_d;
			stall_o            <= stall_d;
			abort_o            <= abort_d;
			clr_l1tlb_mshr_o   <= clr_l1tlb_d;
			clr_l2tlb_mshr_o   <= clr_l2tlb_d;
			clr_dmshr_o        <= clr_dmshr_d;
			synch_l1dc_l2c_o   <= synch_d;
			l1tlb_flush_type_o <= flush_type_d;
			l2tlb_flush_type_o <= flush_type_d;
		end
	end

endmodule

//--- hw/cu_top.sv
//////////////////////////////////////////////////////////////////////
// Inputs are plain levels, outputs follow them after two clock edges
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module cu_top import cu_pkg::*; (
	input  logic         clk_i,
	input  logic         rst_n_i,
	input  instr_t       instr_i,
	input  logic         instr_valid_i,
	input  logic         except_raised_i,
	input  except_code_t except_code_i,
	input  rob_idx_t     commit_head_i,
	input  logic         l2c_update_done_i,
	output logic         flush_o,
	output logic         stall_o,
	output logic         abort_o,
	output logic         clr_l1tlb_mshr_o,
	output logic         clr_l2tlb_mshr_o,
	output logic         clr_dmshr_o,
	output logic         synch_l1dc_l2c_o,
	output tlb_flush_e   l1tlb_flush_type_o,
	output tlb_flush_e   l2tlb_flush_type_o
);

	instr_class_t instr_class;
	instr_class_t held_class;
	cu_state_e    state;

	cu_instr_decode i_decode (
		.instr_i       (instr_i),
		.instr_valid_i (instr_valid_i),
		.instr_class_o (instr_class)
	);

	cu_ctrl_fsm i_fsm (
		.clk_i             (clk_i),
		.rst_n_i           (rst_n_i),
		.instr_class_i     (instr_class),
		.except_raised_i   (except_raised_i),
		.l2c_update_done_i (l2c_update_done_i),
		.state_o           (state),
		.held_class_o      (held_class)
	);

	cu_ctrl_result i_result (
		.clk_i              (clk_i),
		.rst_n_i            (rst_n_i),
		.state_i            (state),
		.held_class_i       (held_class),
		.except_code_i      (except_code_i),
		.commit_head_i      (commit_head_i),
		.flush_o            (flush_o),
		.stall_o            (stall_o),
		.abort_o            (abort_o),
		.clr_l1tlb_mshr_o   (clr_l1tlb_mshr_o),
		.clr_l2tlb_mshr_o   (clr_l2tlb_mshr_o),
		.clr_dmshr_o        (clr_dmshr_o),
		.synch_l1dc_l2c_o   (synch_l1dc_l2c_o),
		.l1tlb_flush_type_o (l1tlb_flush_type_o),
		.l2tlb_flush_type_o (l2tlb_flush_type_o)
	);

endmodule

//--- test/cu_sva.sv
//////////////////////////////////////////////////////////////////////
// Output consistency checks for cu_top, attached with bind
// Reads the FSM state through the state net of cu_top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module cu_sva import cu_pkg::*; (
	input logic       clk_i,
	input logic       rst_n_i,
	input cu_state_e  state_i,
	input logic       flush_i,
	input logic       stall_i,
	input logic       abort_i,
	input logic       clr_l1tlb_mshr_i,
	input logic       clr_l2tlb_mshr_i,
	input logic       clr_dmshr_i,
	input logic       synch_l1dc_l2c_i,
	input tlb_flush_e l1tlb_flush_type_i,
	input tlb_flush_e l2tlb_flush_type_i
);

	logic any_out;

	assign any_out = flush_i | stall_i | abort_i | clr_l1tlb_mshr_i | clr_l2tlb_mshr_i |
		clr_dmshr_i | synch_l1dc_l2c_i | (l1tlb_flush_type_i != NO_FLUSH) |
		(l2tlb_flush_type_i != NO_FLUSH);

	abort_needs_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		abort_i |-> stall_i)
		else $error("abort_o raised without stall_o");

	sync_needs_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		synch_l1dc_l2c_i |-> stall_i)
		else $error("synch_l1dc_l2c_o raised without stall_o");

	flush_all_clears_l1tlb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(l1tlb_flush_type_i == FLUSH_ALL) |-> clr_l1tlb_mshr_i)
		else $error("L1 TLB FLUSH_ALL without the L1 TLB MSHR clear");

	// Outputs lag the state by one edge, stall with flush only out of ST_LDST
	stall_flush_after_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		($past(!stall_i && !flush_i) && stall_i && flush_i) |-> ($past(state_i) == ST_LDST))
		else $error("stall and flush after an idle cycle without a load/store exception");

	// Checked on the falling edge
	idle_in_reset: assert property (@(negedge clk_i) !rst_n_i |-> !any_out)
		else $error("an output is active while reset is asserted");

endmodule

bind cu_top cu_sva i_sva (
	.clk_i              (clk_i),
	.rst_n_i            (rst_n_i),
	.state_i            (state),
	.flush_i            (flush_o),
	.stall_i            (stall_o),
	.abort_i            (abort_o),
	.clr_l1tlb_mshr_i   (clr_l1tlb_mshr_o),
	.clr_l2tlb_mshr_i   (clr_l2tlb_mshr_o),
	.clr_dmshr_i        (clr_dmshr_o),
	.synch_l1dc_l2c_i   (synch_l1dc_l2c_o),
	.l1tlb_flush_type_i (l1tlb_flush_type_o),
	.l2tlb_flush_type_i (l2tlb_flush_type_o)
);

//--- test/cu_tb.sv
//////////////////////////////////////////////////////////////////////
// Table driven, one row per clock, outputs checked two rows later
// The last row stays on the inputs while the final rows are checked
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module cu_tb import cu_pkg::*; ();

	localparam int RESET_CYCLES   = 16;
	localparam int N_ROWS         = 32;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_ROWS + 20;

	localparam instr_t I_NOP    = 32'h0000_0013; // addi x0, x0, 0
	localparam instr_t I_JAL    = 32'h0000_00ef;
	localparam instr_t I_BEQ    = 32'h0000_0063;
	localparam instr_t I_LW     = 32'h0001_2083;
	localparam instr_t I_SW     = 32'h0011_2023;
	localparam instr_t I_FENCE  = 32'h0ff0_000f;
	localparam instr_t I_SFENCE = 32'h1200_0073;
	localparam instr_t I_ECALL  = 32'h0000_0073;
	localparam instr_t I_EBREAK = 32'h0010_0073;

	typedef struct packed {
		instr_t       instr;
		logic         valid;
		logic         exc;
		except_code_t code;
		rob_idx_t     head;
		logic         done;
		logic [6:0]   exp;       // flush stall abort clr_l1tlb clr_l2tlb clr_dmshr sync
		tlb_flush_e   exp_type;  // Same on both TLB levels
	} row_t;

	// instr valid exc code head done, then the outputs seen two rows later
	row_t rows [N_ROWS] = '{
		// JAL without an exception, and an invalid JAL, must not trap
		'{I_JAL,    1, 0, 4'd0,  3'd0, 1, 7'b000_0000, NO_FLUSH},
		'{I_JAL,    0, 1, 4'd0,  3'd0, 1, 7'b000_0000, NO_FLUSH},
		// Jump and branch exceptions
		'{I_JAL,    1, 1, 4'd0,  3'd0, 1, 7'b010_0000, FLUSH_ASID},
		'{I_NOP,    1, 1, 4'd0,  3'd0, 1, 7'b010_0000, FLUSH_ASID},
		'{I_NOP,    1, 0, 4'd0,  3'd0, 1, 7'b000_0000, NO_FLUSH},
		'{I_BEQ,    1, 0, 4'd0,  3'd0, 1, 7'b000_0000, NO_FLUSH},
		'{I_BEQ,    1, 1, 4'd0,  3'd0, 1, 7'b010_0000, FLUSH_ASID},
		'{I_LW,     1, 0, 4'd0,  3'd0, 1, 7'b000_0000, NO_FLUSH},
		'{I_LW,     1, 0, 4'd0,  3'd0, 1, 7'b000_0000, NO_FLUSH},
		// Load/store exception
		'{I_LW,     1, 1, 4'd5,  3'd0, 1, 7'b010_0010, NO_FLUSH},
		'{I_NOP,    1, 1, 4'd5,  3'd7, 1, 7'b110_0010, NO_FLUSH},
		'{I_NOP,    1, 1, 4'd12, 3'd0, 1, 7'b010_1100, NO_FLUSH},
		'{I_NOP,    1, 1, 4'd0,  3'd7, 1, 7'b110_1100, NO_FLUSH},
		'{I_NOP,    1, 1, 4'd2,  3'd0, 1, 7'b011_0000, NO_FLUSH},
		'{I_NOP,    1, 1, 4'd1,  3'd7, 1, 7'b110_1100, NO_FLUSH},
		'{I_NOP,    1, 0, 4'd1,  3'd0, 1, 7'b000_0000, NO_FLUSH},
		'{I_SW,     1, 1, 4'd15, 3'd0, 1, 7'b010_0010, NO_FLUSH},
		'{I_NOP,    1, 0, 4'd15, 3'd0, 1, 7'b000_0000, NO_FLUSH},
		// Fence held off by L2, then one that finishes at once
		'{I_FENCE,  1, 0, 4'd0,  3'd0, 0, 7'b010_0001, NO_FLUSH},
		'{I_NOP,    1, 0, 4'd0,  3'd0, 0, 7'b010_0001, NO_FLUSH},
		'{I_NOP,    1, 0, 4'd0,  3'd0, 0, 7'b010_0001, NO_FLUSH},
		'{I_NOP,    1, 0, 4'd0,  3'd0, 1, 7'b000_0000, NO_FLUSH},
		'{I_FENCE,  1, 0, 4'd0,  3'd0, 1, 7'b010_0001, NO_FLUSH},
		'{I_NOP,    1, 0, 4'd0,  3'd0, 1, 7'b000_0000, NO_FLUSH},
		// sfence.vma clears only in its first cycle
		'{I_SFENCE, 1, 0, 4'd0,  3'd0, 0, 7'b010_1111, FLUSH_ALL},
		'{I_NOP,    1, 0, 4'd0,  3'd0, 0, 7'b010_0001, NO_FLUSH},
		'{I_NOP,    1, 0, 4'd0,  3'd0, 1, 7'b000_0000, NO_FLUSH},
		// ecall alone, ebreak held by an exception
		'{I_ECALL,  1, 0, 4'd0,  3'd0, 1, 7'b010_0000, FLUSH_ASID},
		'{I_NOP,    1, 0, 4'd0,  3'd0, 1, 7'b000_0000, NO_FLUSH},
		'{I_EBREAK, 1, 1, 4'd0,  3'd0, 1, 7'b010_0000, FLUSH_ASID},
		'{I_NOP,    1, 1, 4'd0,  3'd0, 1, 7'b010_0000, FLUSH_ASID},
		'{I_NOP,    1, 0, 4'd0,  3'd0, 1, 7'b000_0000, NO_FLUSH}
	};

	logic         clk_i;
	logic         rst_n_i;
	instr_t       instr_i;
	logic         instr_valid_i;
	logic         except_raised_i;
	except_code_t except_code_i;
	rob_idx_t     commit_head_i;
	logic         l2c_update_done_i;
	logic         flush_o;
	logic         stall_o;
	logic         abort_o;
	logic         clr_l1tlb_mshr_o;
	logic         clr_l2tlb_mshr_o;
	logic         clr_dmshr_o;
	logic         synch_l1dc_l2c_o;
	tlb_flush_e   l1tlb_flush_type_o;
	tlb_flush_e   l2tlb_flush_type_o;

	int cycle_cnt = 0;

	initial clk_i = 1'b0;
	always #50 clk_i = ~clk_i;

	cu_top i_dut (.*);

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL time=%0t signal=%s expected=%0h actual=%0h",
				$time, name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "Output mismatch");
		end
	endtask

	task automatic check_outputs(input logic [6:0] exp, input tlb_flush_e exp_type);
		check_value("flush_o", flush_o, exp[6]);
		check_value("stall_o", stall_o, exp[5]);
		check_value("abort_o", abort_o, exp[4]);
		check_value("clr_l1tlb_mshr_o", clr_l1tlb_mshr_o, exp[3]);
		check_value("clr_l2tlb_mshr_o", clr_l2tlb_mshr_o, exp[2]);
		check_value("clr_dmshr_o", clr_dmshr_o, exp[1]);
		check_value("synch_l1dc_l2c_o", synch_l1dc_l2c_o, exp[0]);
		check_value("l1tlb_flush_type_o", l1tlb_flush_type_o, exp_type);
		check_value("l2tlb_flush_type_o", l2tlb_flush_type_o, exp_type);
	endtask

	initial begin
		int j;

		rst_n_i           = 1'b0;
		instr_i           = I_NOP;
		instr_valid_i     = 1'b0;
		except_raised_i   = 1'b0;
		except_code_i     = '0;
		commit_head_i     = '0;
		l2c_update_done_i = 1'b1;

		repeat (RESET_CYCLES) begin
			@(posedge clk_i);
			@(negedge clk_i);
			check_outputs(7'b000_0000, NO_FLUSH);
		end
		@(posedge clk_i);
		rst_n_i <= 1'b1;
		@(negedge clk_i);
		check_outputs(7'b000_0000, NO_FLUSH);
		@(negedge clk_i);
		check_outputs(7'b100_1110, FLUSH_ALL); // One-shot pulse out of ST_RESET
		@(negedge clk_i);
		check_outputs(7'b000_0000, NO_FLUSH);

		// Last row stays on the inputs while the final two rows are checked
		for (j = 0; j < N_ROWS + 2; j++) begin
			@(posedge clk_i);
			if (j < N_ROWS) begin
				instr_i           <= rows[j].instr;
				instr_valid_i     <= rows[j].valid;
				except_raised_i   <= rows[j].exc;
				except_code_i     <= rows[j].code;
				commit_head_i     <= rows[j].head;
				l2c_update_done_i <= rows[j].done;
			end
			@(negedge clk_i);
			if (j >= 2) begin
				check_outputs(rows[j-2].exp, rows[j-2].exp_type);
			end
		end

		$display("STATUS: PASS");
		$finish;
	end

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("ERROR: run hung, still going after %0d cycles", cycle_cnt);
			$display("STATUS: FAIL");
			$fatal(1, "Timeout");
		end
	end

endmodule

//--- cu_top.f
hw/cu_pkg.sv
hw/cu_instr_decode.sv
hw/cu_ctrl_fsm.sv
hw/cu_ctrl_result.sv
hw/cu_top.sv
test/cu_sva.sv
test/cu_tb.sv
